// ==== spi_master.f ====
+incdir+.
spi_frame_pkg.sv
spi_control_pkg.sv
spi_shift_if.sv
spi_bit_timer.sv
spi_sequencer.sv
spi_shifter.sv
spi_master.sv
tb_spi_master.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the SPI master testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert -j 0 --top-module tb_spi_master -f spi_master.f \
    -o sim_spi_master

./obj_dir/sim_spi_master | tee sim.log

# Exit status follows the result line in the log
grep -q "Testbench passed" sim.log

// ==== tb_spi_master.sv ====
`timescale 1ns/1ns
`include "spi_master_defs.svh"

module tb_spi_master;

    localparam logic leading_mode  = 1'b0;
    localparam logic trailing_mode = 1'b1;

    logic                          clock;
    logic                          reset_n;
    logic [`SPI_DATA_WIDTH-1:0]    data;
    logic [`SPI_ADDRESS_WIDTH-1:0] address;
    logic                          read_write;
    logic                          enable;
    logic [`SPI_DIVIDER_WIDTH-1:0] divider;
    logic                          clock_phase;
    logic                          master_in_slave_out = 1'b0;
    logic                          serial_clock;
    logic                          slave_select;
    logic                          master_out_slave_in;
    logic                          busy;
    logic [`SPI_DATA_WIDTH-1:0]    read_data;
    logic                          read_data_valid;

    integer seed;
    integer mismatch_count = 0;
    integer failure_count = 0;
    string  test_name = "reset";

    // Slave side bookkeeping
    logic [`SPI_FRAME_BITS-1:0] slave_response = '0;
    logic [`SPI_FRAME_BITS-1:0] slave_shift = '0;
    logic [`SPI_FRAME_BITS-1:0] slave_received = '0;
    logic [`SPI_FRAME_BITS-1:0] expected = '0;
    logic [`SPI_DATA_WIDTH-1:0] expected_read = '0;
    logic                       last_serial_clock = 1'b0;
    logic                       last_slave_select = 1'b1;
    integer                     rise_count = 0;
    integer                     high_clocks = 0;
    integer                     expected_high = 0;
    integer                     valid_count = 0;

    spi_master UUT (
        .clock               (clock),
        .reset_n             (reset_n),
        .data                (data),
        .address             (address),
        .read_write          (read_write),
        .enable              (enable),
        .divider             (divider),
        .clock_phase         (clock_phase),
        .master_in_slave_out (master_in_slave_out),
        .serial_clock        (serial_clock),
        .slave_select        (slave_select),
        .master_out_slave_in (master_out_slave_in),
        .busy                (busy),
        .read_data           (read_data),
        .read_data_valid     (read_data_valid)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Frame as it should appear on the wire, MSB first
    function automatic logic [`SPI_FRAME_BITS-1:0] expected_frame(
        input logic [`SPI_ADDRESS_WIDTH-1:0] frame_address,
        input logic                          frame_read_write,
        input logic [`SPI_DATA_WIDTH-1:0]    frame_data
    );
        expected_frame = {frame_address, frame_read_write, frame_data};
    endfunction

    task automatic compare_value(input string what, input logic [31:0] expected_value,
                                 input logic [31:0] actual_value);
        assert (actual_value === expected_value) else begin
            $display("Mismatch %s %s: expected %h, actual %h", test_name, what,
                     expected_value, actual_value);
            mismatch_count = mismatch_count + 1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Slave model and serial clock monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (last_slave_select && !slave_select) begin
            slave_shift    = slave_response;
            slave_received = '0;
            rise_count     = 0;
            // Leading mode needs the first bit before the first rising edge
            if (clock_phase == leading_mode) begin
                master_in_slave_out <= slave_shift[`SPI_FRAME_BITS-1];
                slave_shift = slave_shift << 1;
            end
        end
        if (serial_clock && !last_serial_clock) begin
            high_clocks = 0;
            if (!slave_select) begin
                rise_count = rise_count + 1;
            end
            if (clock_phase == leading_mode) begin
                slave_received = {slave_received[`SPI_FRAME_BITS-2:0], master_out_slave_in};
            end else begin
                master_in_slave_out <= slave_shift[`SPI_FRAME_BITS-1];
                slave_shift = slave_shift << 1;
            end
        end
        if (!serial_clock && last_serial_clock) begin
            compare_value("serial_clock high clocks", expected_high, high_clocks);
            if (clock_phase == leading_mode) begin
                master_in_slave_out <= slave_shift[`SPI_FRAME_BITS-1];
                slave_shift = slave_shift << 1;
            end else begin
                slave_received = {slave_received[`SPI_FRAME_BITS-2:0], master_out_slave_in};
            end
        end
        if (serial_clock) begin
            high_clocks = high_clocks + 1;
        end
        last_serial_clock = serial_clock;
        last_slave_select = slave_select;
    end

    // Compare results at each read_data_valid pulse
    always @(negedge clock) begin
        if (read_data_valid === 1'b1) begin
            valid_count = valid_count + 1;
            compare_value("read_data", 32'(expected_read), 32'(read_data));
            compare_value("slave frame", expected, slave_received);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_transaction(input string name, input logic phase, input logic rw,
                                   input logic [`SPI_DIVIDER_WIDTH-1:0] div,
                                   input logic enable_again);
        logic [31:0] random_word;
        integer      wait_count;
        integer      valid_before;
        test_name      = name;
        random_word    = $random(seed);
        address        = random_word[`SPI_ADDRESS_WIDTH-1:0];
        random_word    = $random(seed);
        data           = random_word[`SPI_DATA_WIDTH-1:0];
        slave_response = $random(seed);
        read_write     = rw;
        clock_phase    = phase;
        divider        = div;
        expected       = expected_frame(address, rw, data);
        expected_read  = slave_response[`SPI_DATA_WIDTH-1:0];
        expected_high  = 2 * (div + 1);
        valid_before   = valid_count;
        enable         = 1'b1;
        @(negedge clock);
        enable = 1'b0;
        assert (busy === 1'b1) else begin
            $display("%s: busy did not rise after enable", name);
            failure_count = failure_count + 1;
        end
        if (enable_again) begin
            repeat (8) @(negedge clock);
            address    = ~address;
            data       = ~data;
            read_write = ~rw;
            enable     = 1'b1;
            @(negedge clock);
            enable = 1'b0;
        end
        wait_count = 0;
        while (busy && wait_count < 5000) begin
            @(negedge clock);
            wait_count = wait_count + 1;
        end
        assert (!busy) else begin
            $display("%s: timed out waiting for busy to fall", name);
            failure_count = failure_count + 1;
        end
        compare_value("read_data_valid pulses", 32'd1, valid_count - valid_before);
        compare_value("serial_clock rising edges", 32'(`SPI_FRAME_BITS), rise_count);
        compare_value("read/write bit", 32'(rw), 32'(slave_received[`SPI_DATA_WIDTH]));
        compare_value("slave_select after frame", 32'd1, 32'(slave_select));
        repeat (3) @(negedge clock);
    endtask

    initial begin
        seed        = 33214;
        reset_n     = 1'b0;
        data        = '0;
        address     = '0;
        read_write  = 1'b0;
        enable      = 1'b0;
        divider     = 16'd1;
        clock_phase = leading_mode;
        repeat (3) @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);

        compare_value("busy", 32'd0, 32'(busy));
        compare_value("serial_clock", 32'd0, 32'(serial_clock));
        compare_value("read_data_valid", 32'd0, 32'(read_data_valid));
        compare_value("slave_select", 32'd1, 32'(slave_select));
        compare_value("master_out_slave_in", 32'd0, 32'(master_out_slave_in));
        compare_value("read_data", 32'd0, 32'(read_data));

        run_transaction("write_leading", leading_mode, 1'b0, 16'd1, 1'b0);
        run_transaction("read_leading", leading_mode, 1'b1, 16'd1, 1'b0);
        run_transaction("write_trailing", trailing_mode, 1'b0, 16'd1, 1'b0);
        run_transaction("read_trailing", trailing_mode, 1'b1, 16'd1, 1'b0);
        run_transaction("divider_0", leading_mode, 1'b0, 16'd0, 1'b0);
        run_transaction("divider_1", trailing_mode, 1'b1, 16'd1, 1'b0);
        run_transaction("divider_3", leading_mode, 1'b1, 16'd3, 1'b0);
        run_transaction("enable_while_busy", trailing_mode, 1'b0, 16'd2, 1'b1);

        $display("Error count: %0d mismatches, %0d other failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== spi_master.sv ====
`timescale 1ns/1ns
`include "spi_master_defs.svh"

module spi_master (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic [`SPI_DATA_WIDTH-1:0]    data,
    input  logic [`SPI_ADDRESS_WIDTH-1:0] address,
    input  logic                          read_write,
    input  logic                          enable,
    input  logic [`SPI_DIVIDER_WIDTH-1:0] divider,
    input  logic                          clock_phase,
    input  logic                          master_in_slave_out,
    output logic                          serial_clock,
    output logic                          slave_select,
    output logic                          master_out_slave_in,
    output logic                          busy,
    output logic [`SPI_DATA_WIDTH-1:0]    read_data,
    output logic                          read_data_valid
);

    logic                         tick;
    logic                         stepping;
    spi_control_pkg::clock_step_e step;

    spi_shift_if shift_bus ();

    spi_bit_timer bit_timer (
        .clock    (clock),
        .reset_n  (reset_n),
        .divider  (divider),
        .stepping (stepping),
        .tick     (tick),
        .step     (step)
    );

    spi_sequencer sequencer (
        .clock        (clock),
        .reset_n      (reset_n),
        .enable       (enable),
        .read_write   (read_write),
        .clock_phase  (spi_control_pkg::clock_phase_e'(clock_phase)),
        .tick         (tick),
        .step         (step),
        .stepping     (stepping),
        .busy         (busy),
        .slave_select (slave_select),
        .serial_clock (serial_clock),
        .shift        (shift_bus.sequencer)
    );

    spi_shifter shifter (
        .clock               (clock),
        .reset_n             (reset_n),
        .address             (address),
        .data                (data),
        .read_write          (read_write),
        .master_in_slave_out (master_in_slave_out),
        .shift               (shift_bus.shifter),
        .master_out_slave_in (master_out_slave_in),
        .read_data           (read_data),
        .read_data_valid     (read_data_valid)
    );

endmodule

// ==== spi_shifter.sv ====
`timescale 1ns/1ns
`include "spi_master_defs.svh"

module spi_shifter (
    input  logic                    clock,
    input  logic                    reset_n,
    input  spi_frame_pkg::address_t address,
    input  spi_frame_pkg::data_t    data,
    input  logic                    read_write,
    input  logic                    master_in_slave_out,
    spi_shift_if.shifter            shift,
    output logic                    master_out_slave_in,
    output spi_frame_pkg::data_t    read_data,
    output logic                    read_data_valid
);

    spi_frame_pkg::frame_t out_frame;
    spi_frame_pkg::frame_t in_frame;

    ////////////////////////////////////////////////////////////////////////
    // Frame shift registers
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (shift.load) begin
            out_frame <= {address, read_write, data};
        end else if (shift.deselect) begin
            out_frame <= '0;
        end else if (shift.launch) begin
            out_frame <= {out_frame[`SPI_FRAME_BITS-2:0], 1'b0};
        end
        if (shift.capture) begin
            in_frame <= {in_frame[`SPI_FRAME_BITS-2:0], master_in_slave_out};
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Serial output and read data
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            master_out_slave_in <= 1'b0;
            read_data           <= '0;
            read_data_valid     <= 1'b0;
        end else begin
            read_data_valid <= shift.finish;
            if (shift.launch) begin
                master_out_slave_in <= out_frame[`SPI_FRAME_BITS-1];
            end else if (shift.finish || shift.deselect) begin
                master_out_slave_in <= 1'b0;
            end
            // Slave word is the last bits shifted in
            if (shift.finish) begin
                read_data <= in_frame[`SPI_DATA_WIDTH-1:0];
            end
        end
    end

endmodule

// ==== spi_sequencer.sv ====
`timescale 1ns/1ns
`include "spi_master_defs.svh"

module spi_sequencer (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         enable,
    input  logic                         read_write,
    input  spi_control_pkg::clock_phase_e clock_phase,
    input  logic                         tick,
    input  spi_control_pkg::clock_step_e step,
    output logic                         stepping,
    output logic                         busy,
    output logic                         slave_select,
    output logic                         serial_clock,
    spi_shift_if.sequencer               shift
);

    // Address bits plus the read/write bit, counted from zero
    localparam logic [`SPI_BIT_COUNT_WIDTH-1:0] last_address_bit = `SPI_ADDRESS_WIDTH;
    localparam logic [`SPI_BIT_COUNT_WIDTH-1:0] last_data_bit = `SPI_DATA_WIDTH - 1;

    spi_control_pkg::master_state_e state;
    spi_control_pkg::clock_phase_e  saved_phase;
    logic [`SPI_BIT_COUNT_WIDTH-1:0] bit_count;
    logic                           data_phase;
    logic                           leading;
    logic                           last_bit;
    logic                           first_bit;

    assign data_phase = (state == spi_control_pkg::send_address) ||
                        (state == spi_control_pkg::transfer_data);
    assign leading    = (saved_phase == spi_control_pkg::phase_leading);
    assign first_bit  = (state == spi_control_pkg::send_address) && (bit_count == '0);
    assign last_bit   = (state == spi_control_pkg::send_address) ?
                        (bit_count == last_address_bit) : (bit_count == last_data_bit);

    assign stepping = data_phase || (state == spi_control_pkg::stop);

    ////////////////////////////////////////////////////////////////////////
    // Shift strobes
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        shift.load     = (state == spi_control_pkg::idle) && enable;
        shift.launch   = 1'b0;
        shift.capture  = 1'b0;
        shift.finish   = 1'b0;
        shift.deselect = 1'b0;
        if (tick) begin
            if (state == spi_control_pkg::select) begin
                // First bit goes out with slave select in leading mode
                shift.launch = leading;
            end else if (data_phase) begin
                if (leading) begin
                    shift.capture = (step == spi_control_pkg::step_hold);
                    shift.launch  = (step == spi_control_pkg::step_fall);
                end else begin
                    shift.launch  = (step == spi_control_pkg::step_rise);
                    shift.capture = (step == spi_control_pkg::step_setup) && !first_bit;
                end
            end else if (state == spi_control_pkg::stop) begin
                // Last trailing bit is sampled one setup step late
                shift.capture  = !leading && (step == spi_control_pkg::step_setup);
                shift.finish   = (step == spi_control_pkg::step_rise);
                shift.deselect = (step == spi_control_pkg::step_fall);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Transaction FSM
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state        <= spi_control_pkg::idle;
            saved_phase  <= spi_control_pkg::phase_leading;
            bit_count    <= '0;
            busy         <= 1'b0;
            slave_select <= 1'b1;
            serial_clock <= 1'b0;
        end else begin
            case (state)
                spi_control_pkg::idle: begin
                    if (enable) begin
                        busy        <= 1'b1;
                        saved_phase <= clock_phase;
                        bit_count   <= '0;
                        state       <= spi_control_pkg::select;
                    end
                end
                spi_control_pkg::select: begin
                    if (tick) begin
                        slave_select <= 1'b0;
                        state        <= spi_control_pkg::send_address;
                    end
                end
                spi_control_pkg::send_address, spi_control_pkg::transfer_data: begin
                    if (tick && step == spi_control_pkg::step_rise) begin
                        serial_clock <= 1'b1;
                    end
                    if (tick && step == spi_control_pkg::step_fall) begin
                        serial_clock <= 1'b0;
                        if (!last_bit) begin
                            bit_count <= bit_count + 1'b1;
                        end else if (state == spi_control_pkg::send_address) begin
                            bit_count <= '0;
                            // Reads keep the data word in the frame
                            state <= spi_control_pkg::transfer_data;
                        end else begin
                            state <= spi_control_pkg::stop;
                        end
                    end
                end
                spi_control_pkg::stop: begin
                    if (tick && step == spi_control_pkg::step_rise) begin
                        slave_select <= 1'b1;
                    end
                    if (tick && step == spi_control_pkg::step_fall) begin
                        busy  <= 1'b0;
                        state <= spi_control_pkg::idle;
                    end
                end
                default: begin
                    state <= spi_control_pkg::idle;
                end
            endcase
        end
    end

endmodule

// ==== spi_bit_timer.sv ====
`timescale 1ns/1ns

module spi_bit_timer (
    input  logic                        clock,
    input  logic                        reset_n,
    input  spi_frame_pkg::divider_t     divider,
    input  logic                        stepping,
    output logic                        tick,
    output spi_control_pkg::clock_step_e step
);

    spi_frame_pkg::divider_t divider_count;

    ////////////////////////////////////////////////////////////////////////
    // Free running divider
    ////////////////////////////////////////////////////////////////////////

    // Compare with >= so a smaller new divider does not wait for a wrap
    assign tick = (divider_count >= divider);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            divider_count <= '0;
        end else if (tick) begin
            divider_count <= '0;
        end else begin
            divider_count <= divider_count + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Bit step counter
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            step <= spi_control_pkg::step_setup;
        end else if (!stepping) begin
            step <= spi_control_pkg::step_setup;
        end else if (tick) begin
            // Fall wraps back to setup of the next bit
            step <= spi_control_pkg::clock_step_e'(step + 2'd1);
        end
    end

endmodule

// ==== spi_shift_if.sv ====
`timescale 1ns/1ns

interface spi_shift_if;

    // Capture the request into the outgoing frame
    logic load;

    // Drive the frame MSB and shift left
    logic launch;

    // Shift the slave bit into the incoming frame
    logic capture;

    // End of frame, publish read data
    logic finish;

    // Slave released, nothing left to drive
    logic deselect;

    modport sequencer (
        output load,
        output launch,
        output capture,
        output finish,
        output deselect
    );

    modport shifter (
        input load,
        input launch,
        input capture,
        input finish,
        input deselect
    );

endinterface

// ==== spi_control_pkg.sv ====
package spi_control_pkg;

    // Transaction sequencer states
    typedef enum logic [2:0] {
        idle,
        select,
        send_address,
        transfer_data,
        stop
    } master_state_e;

    // Leading samples on the rising edge, trailing on the falling edge
    typedef enum logic {
        phase_leading,
        phase_trailing
    } clock_phase_e;

    // Four ticks per serial bit
    typedef enum logic [1:0] {
        step_setup,
        step_rise,
        step_hold,
        step_fall
    } clock_step_e;

endpackage

// ==== spi_frame_pkg.sv ====
`include "spi_master_defs.svh"

package spi_frame_pkg;

    ////////////////////////////////////////////////////////////////////////
    // Frame fields
    ////////////////////////////////////////////////////////////////////////

    // Register address sent first, MSB first
    typedef logic [`SPI_ADDRESS_WIDTH-1:0] address_t;

    // Data word, sent on writes and returned by the slave
    typedef logic [`SPI_DATA_WIDTH-1:0] data_t;

    // Whole frame as it sits in the shift registers
    typedef logic [`SPI_FRAME_BITS-1:0] frame_t;

    ////////////////////////////////////////////////////////////////////////
    // Clock divider
    ////////////////////////////////////////////////////////////////////////

    // One tick every divider+1 clocks
    typedef logic [`SPI_DIVIDER_WIDTH-1:0] divider_t;

endpackage

// ==== spi_master_defs.svh ====
`ifndef SPI_MASTER_DEFS_SVH
`define SPI_MASTER_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Frame geometry
////////////////////////////////////////////////////////////////////////////

`define SPI_ADDRESS_WIDTH 15
`define SPI_DATA_WIDTH 16

// Address, read/write bit, data word
`define SPI_FRAME_BITS (`SPI_ADDRESS_WIDTH + 1 + `SPI_DATA_WIDTH)

////////////////////////////////////////////////////////////////////////////
// Counters
////////////////////////////////////////////////////////////////////////////

`define SPI_DIVIDER_WIDTH 16
`define SPI_BIT_COUNT_WIDTH 8

`endif
